// ==== merge_types_pkg.sv ====
package merge_types_pkg;

    // ----------------------------------------------------------------------
    // Lane and data sizing
    // ----------------------------------------------------------------------
    localparam int num_lanes = 4;
    localparam int data_w    = 32;
    localparam int meta_w    = 8;

    // ----------------------------------------------------------------------
    // Lane side
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [meta_w-1:0] meta;
        logic [data_w-1:0] data;
    } lane_word_t;

    typedef struct packed {
        logic       valid;
        lane_word_t word;
    } lane_beat_t;

    // ----------------------------------------------------------------------
    // Merged side
    // ----------------------------------------------------------------------
    // Field j is filled from lane j
    typedef struct packed {
        logic [meta_w-1:0]                 meta;
        logic [num_lanes-1:0][data_w-1:0]  field;
    } merged_packet_t;

    typedef struct packed {
        logic           valid;
        merged_packet_t packet;
    } merged_beat_t;

endpackage

// ==== merge_ctrl_pkg.sv ====
package merge_ctrl_pkg;

    // ----------------------------------------------------------------------
    // FIFO sizing
    // ----------------------------------------------------------------------
    localparam int lane_fifo_depth = 16;
    localparam int out_fifo_depth  = 16;

    // Occupancy at which almost_full is raised
    localparam int prog_thresh     = 8;

    // ----------------------------------------------------------------------
    // Configuration
    // ----------------------------------------------------------------------
    // One enable bit per lane, bit j for lane j
    typedef struct packed {
        logic [merge_types_pkg::num_lanes-1:0] mask;
    } merge_cfg_t;

    // ----------------------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        idle  = 2'd0,
        run   = 2'd1,
        pause = 2'd2
    } merge_state_t;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 16
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     dout_valid,
    output logic     empty,
    output logic     almost_full
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] count_t;

    payload_t mem [depth];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   full;
    logic   do_push;
    logic   do_pop;

    // ----------------------------------------------------------------------
    // Status flags
    // ----------------------------------------------------------------------
    assign full        = (count == count_t'(depth));
    assign empty       = (count == '0);
    assign almost_full = (count >= count_t'(merge_ctrl_pkg::prog_thresh));

    // Requests against a full or empty buffer are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dout_valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
            // Popped word shows for exactly one cycle
            dout_valid <= do_pop;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== merge_control.sv ====
`timescale 1ns/100ps

module merge_control (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       cfg_valid,
    input  merge_ctrl_pkg::merge_cfg_t cfg_mask,
    input  logic                       stop,
    input  logic                       out_almost_full,
    output logic                       capture_en,
    output merge_ctrl_pkg::merge_cfg_t active_cfg,
    output logic                       running
);

    merge_ctrl_pkg::merge_state_t state;
    merge_ctrl_pkg::merge_state_t next_state;
    logic                         cfg_accept;

    // Only a nonzero mask offered while idle starts a run
    assign cfg_accept = cfg_valid && (cfg_mask.mask != '0) &&
                        (state == merge_ctrl_pkg::idle);

    // ----------------------------------------------------------------------
    // State machine
    // ----------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            merge_ctrl_pkg::idle: begin
                if (cfg_accept) begin
                    next_state = merge_ctrl_pkg::run;
                end
            end
            merge_ctrl_pkg::run: begin
                if (stop) begin
                    next_state = merge_ctrl_pkg::idle;
                end else if (out_almost_full) begin
                    next_state = merge_ctrl_pkg::pause;
                end
            end
            merge_ctrl_pkg::pause: begin
                if (stop) begin
                    next_state = merge_ctrl_pkg::idle;
                end else if (!out_almost_full) begin
                    next_state = merge_ctrl_pkg::run;
                end
            end
            default: next_state = merge_ctrl_pkg::idle;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= merge_ctrl_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------------------------------------
    // Lane mask
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            active_cfg.mask <= '1;
        end else if (cfg_accept) begin
            active_cfg <= cfg_mask;
        end else if (stop) begin
            active_cfg.mask <= '1;
        end
    end

    assign capture_en = (state == merge_ctrl_pkg::run);
    assign running    = (state == merge_ctrl_pkg::run) || (state == merge_ctrl_pkg::pause);

endmodule

// ==== merge_gather.sv ====
`timescale 1ns/100ps

module merge_gather (
    input  logic                                  ap_clk,
    input  logic                                  areset_generator,
    input  logic                                  capture_en,
    input  merge_ctrl_pkg::merge_cfg_t            active_cfg,
    input  merge_types_pkg::lane_beat_t           lane_head [merge_types_pkg::num_lanes],
    input  logic [merge_types_pkg::num_lanes-1:0] lane_empty,
    output logic [merge_types_pkg::num_lanes-1:0] lane_pop,
    output merge_types_pkg::merged_beat_t         merged
);

    logic [merge_types_pkg::num_lanes-1:0] lane_done;
    logic [merge_types_pkg::num_lanes-1:0] lane_arrive;
    logic [merge_types_pkg::num_lanes-1:0] lane_complete;
    logic                                  all_done;

    // ----------------------------------------------------------------------
    // Pop decisions
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < merge_types_pkg::num_lanes; i++) begin
            // A word on the head means a pop is still in flight
            lane_pop[i] = capture_en & ~lane_empty[i] & ~lane_done[i] &
                          ~lane_head[i].valid;

            // Masked-off lanes are popped too, but their words are dropped
            lane_arrive[i]   = lane_head[i].valid & active_cfg.mask[i];
            lane_complete[i] = lane_done[i] | ~active_cfg.mask[i];
        end
    end

    assign all_done = &lane_complete;

    // ----------------------------------------------------------------------
    // Capture registers and done flags
    // ----------------------------------------------------------------------
    // Fields of masked lanes are left alone and keep their last value.
    // Flags are only cleared by a merge, so they ride through a pause.
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            lane_done <= '0;
            merged    <= '0;
        end else begin
            merged.valid <= all_done;

            if (all_done) begin
                lane_done <= '0;
            end else begin
                lane_done <= lane_done | lane_arrive;
            end

            for (int i = 0; i < merge_types_pkg::num_lanes; i++) begin
                if (lane_arrive[i]) begin
                    merged.packet.field[i] <= lane_head[i].word.data;
                end
            end

            // Meta tag follows lane 0
            if (lane_arrive[0]) begin
                merged.packet.meta <= lane_head[0].word.meta;
            end
        end
    end

endmodule

// ==== merge_data_generator.sv ====
`timescale 1ns/100ps

module merge_data_generator (
    input  logic                                  ap_clk,
    input  logic                                  areset_generator,
    input  merge_types_pkg::lane_beat_t           lane_in [merge_types_pkg::num_lanes],
    output logic [merge_types_pkg::num_lanes-1:0] lane_almost_full,
    input  logic                                  cfg_valid,
    input  merge_ctrl_pkg::merge_cfg_t            cfg_mask,
    input  logic                                  stop,
    output logic                                  running,
    output merge_types_pkg::merged_beat_t         out,
    input  logic                                  out_ready
);

    merge_types_pkg::lane_word_t           lane_word       [merge_types_pkg::num_lanes];
    logic [merge_types_pkg::num_lanes-1:0] lane_word_valid;
    merge_types_pkg::lane_beat_t           lane_head       [merge_types_pkg::num_lanes];
    logic [merge_types_pkg::num_lanes-1:0] lane_empty;
    logic [merge_types_pkg::num_lanes-1:0] lane_pop;

    logic                                  capture_en;
    merge_ctrl_pkg::merge_cfg_t            active_cfg;
    merge_types_pkg::merged_beat_t         merged;

    merge_types_pkg::merged_packet_t       out_packet;
    logic                                  out_valid;
    logic                                  out_empty;
    logic                                  out_almost_full;
    logic                                  out_pop;

    // ----------------------------------------------------------------------
    // Lane FIFOs
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < merge_types_pkg::num_lanes; i++) begin : g_lane
        sync_fifo #(
            .payload_t(merge_types_pkg::lane_word_t),
            .depth    (merge_ctrl_pkg::lane_fifo_depth)
        ) u_lane_fifo (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .push            (lane_in[i].valid),
            .din             (lane_in[i].word),
            .pop             (lane_pop[i]),
            .dout            (lane_word[i]),
            .dout_valid      (lane_word_valid[i]),
            .empty           (lane_empty[i]),
            .almost_full     (lane_almost_full[i])
        );

        assign lane_head[i] = '{valid: lane_word_valid[i], word: lane_word[i]};
    end

    // ----------------------------------------------------------------------
    // Control and gather
    // ----------------------------------------------------------------------
    merge_control u_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_valid       (cfg_valid),
        .cfg_mask        (cfg_mask),
        .stop            (stop),
        .out_almost_full (out_almost_full),
        .capture_en      (capture_en),
        .active_cfg      (active_cfg),
        .running         (running)
    );

    merge_gather u_gather (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .capture_en      (capture_en),
        .active_cfg      (active_cfg),
        .lane_head       (lane_head),
        .lane_empty      (lane_empty),
        .lane_pop        (lane_pop),
        .merged          (merged)
    );

    // ----------------------------------------------------------------------
    // Output FIFO
    // ----------------------------------------------------------------------
    assign out_pop = ~out_empty & out_ready;

    sync_fifo #(
        .payload_t(merge_types_pkg::merged_packet_t),
        .depth    (merge_ctrl_pkg::out_fifo_depth)
    ) u_out_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (merged.valid),
        .din             (merged.packet),
        .pop             (out_pop),
        .dout            (out_packet),
        .dout_valid      (out_valid),
        .empty           (out_empty),
        .almost_full     (out_almost_full)
    );

    assign out = '{valid: out_valid, packet: out_packet};

endmodule

// ==== merge_data_generator_sva.sv ====
`timescale 1ns/100ps

module merge_data_generator_sva (
    input logic                                  ap_clk,
    input logic                                  areset_generator,
    input logic                                  stop,
    input logic                                  running,
    input logic                                  out_valid,
    input logic                                  out_ready,
    input logic [merge_types_pkg::num_lanes-1:0] lane_pop,
    input logic [merge_types_pkg::num_lanes-1:0] lane_word_valid
);

    // Output FIFO only pops on a ready consumer
    out_needs_ready: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        $rose(out_valid) |-> $past(out_ready)
    ) else $error("out.valid rose after a cycle with out_ready low");

    stop_clears_running: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        stop |=> !running
    ) else $error("running still high in the cycle after stop");

    // A pop that hits a non-empty lane FIFO shows its word on the next cycle
    no_pop_when_empty: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (lane_pop != '0) |=> ((lane_word_valid & $past(lane_pop)) == $past(lane_pop))
    ) else $error("lane_pop issued to an empty lane FIFO");

endmodule

bind merge_data_generator merge_data_generator_sva u_sva (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .stop            (stop),
    .running         (running),
    .out_valid       (out.valid),
    .out_ready       (out_ready),
    .lane_pop        (lane_pop),
    .lane_word_valid (lane_word_valid)
);

// ==== merge_data_generator_tb.sv ====
`timescale 1ns/100ps

module merge_data_generator_tb;

    typedef logic [merge_types_pkg::num_lanes-1:0] lane_mask_t;

    localparam int full_beats   = 12;
    localparam int masked_beats = 8;
    localparam int masked_runs  = 3;
    localparam int ctrl_beats   = 6;
    localparam int bp_beats     = 24;
    localparam int idle_beats   = 5;
    localparam int total_pushes = full_beats + masked_runs * masked_beats + ctrl_beats +
                                  bp_beats + idle_beats;
    localparam int limit_cycles = total_pushes * 40 + 400;

    // Beats paced to the merge rate, so the output FIFO fills before the lanes do
    localparam int bp_gap       = 2;

    logic                            ap_clk;
    logic                            areset_generator;
    merge_types_pkg::lane_beat_t     lane_in [merge_types_pkg::num_lanes];
    lane_mask_t                      lane_almost_full;
    logic                            cfg_valid;
    merge_ctrl_pkg::merge_cfg_t      cfg_mask;
    logic                            stop;
    logic                            running;
    merge_types_pkg::merged_beat_t   out;
    logic                            out_ready;

    // Reference model of the merge
    merge_types_pkg::lane_word_t        lane_q [merge_types_pkg::num_lanes][$];
    logic [merge_types_pkg::data_w-1:0] held_field [merge_types_pkg::num_lanes];
    logic [merge_types_pkg::meta_w-1:0] held_meta;
    lane_mask_t                         model_mask;
    logic                               model_running;

    integer seed;
    int     value_errors;
    int     other_errors;
    int     packets_checked;
    string  test_name;

    merge_data_generator DUT (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .lane_in         (lane_in),
        .lane_almost_full(lane_almost_full),
        .cfg_valid       (cfg_valid),
        .cfg_mask        (cfg_mask),
        .stop            (stop),
        .running         (running),
        .out             (out),
        .out_ready       (out_ready)
    );

    always #10 ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    task automatic clear_lanes();
        for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
            lane_in[j] = '0;
        end
    endtask

    function automatic lane_mask_t random_mask();
        lane_mask_t m;
        m = '0;
        while (m == '0) begin
            m = lane_mask_t'($random(seed));
        end
        return m;
    endfunction

    // One beat every gap+1 cycles into the selected lanes, held off by lane_almost_full
    task automatic push_beats(input int count, input lane_mask_t sel, input int gap);
        merge_types_pkg::lane_word_t w;
        for (int k = 0; k < count; k++) begin
            @(posedge ap_clk);
            #2;
            clear_lanes();
            repeat (gap) begin
                @(posedge ap_clk);
                #2;
            end
            while ((lane_almost_full & sel) != '0) begin
                @(posedge ap_clk);
                #2;
            end
            for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
                if (sel[j]) begin
                    w.data = $random(seed);
                    w.meta = 8'($random(seed));
                    lane_in[j].valid = 1'b1;
                    lane_in[j].word  = w;
                    // Words into masked lanes during a run are thrown away
                    if (!model_running || model_mask[j]) begin
                        lane_q[j].push_back(w);
                    end
                end
            end
        end
        @(posedge ap_clk);
        #2;
        clear_lanes();
    endtask

    task automatic configure(input lane_mask_t mask);
        @(posedge ap_clk);
        #2;
        cfg_valid     = 1'b1;
        cfg_mask.mask = mask;
        @(posedge ap_clk);
        #2;
        cfg_valid = 1'b0;
        if ((mask != '0) && !model_running) begin
            model_running = 1'b1;
            model_mask    = mask;
            // Words left in masked lanes from idle get discarded by the run
            for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
                if (!mask[j]) begin
                    lane_q[j].delete();
                end
            end
        end
        @(negedge ap_clk);
        if (running !== model_running) begin
            $display("FAIL %s running after cfg_valid: expected %b, actual %b",
                     test_name, model_running, running);
            value_errors++;
        end
    endtask

    task automatic stop_run();
        @(posedge ap_clk);
        #2;
        stop = 1'b1;
        @(posedge ap_clk);
        #2;
        stop          = 1'b0;
        model_running = 1'b0;
        @(negedge ap_clk);
        if (running !== 1'b0) begin
            $display("FAIL %s running after stop: expected 0, actual %b", test_name, running);
            value_errors++;
        end
    endtask

    // Done once the model has matched every pending word of the enabled lanes
    task automatic wait_drain();
        logic pending;
        do begin
            @(posedge ap_clk);
            #2;
            pending = 1'b0;
            for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
                if (model_mask[j] && lane_q[j].size() != 0) begin
                    pending = 1'b1;
                end
            end
        end while (pending);
    endtask

    // ----------------------------------------------------------------------
    // Output checking
    // ----------------------------------------------------------------------
    task automatic check_packet(input merge_types_pkg::merged_packet_t got);
        merge_types_pkg::lane_word_t w;
        for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
            if (model_mask[j]) begin
                if (lane_q[j].size() == 0) begin
                    $display("ERROR: %s packet %0d arrived with no word pending on lane %0d",
                             test_name, packets_checked, j);
                    other_errors++;
                end else begin
                    w = lane_q[j].pop_front();
                    held_field[j] = w.data;
                    if (j == 0) begin
                        held_meta = w.meta;
                    end
                end
            end
        end
        if (got.meta != held_meta) begin
            $display("FAIL %s packet %0d meta: expected %h, actual %h",
                     test_name, packets_checked, held_meta, got.meta);
            value_errors++;
        end
        for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
            if (got.field[j] != held_field[j]) begin
                $display("FAIL %s packet %0d field %0d: expected %h, actual %h",
                         test_name, packets_checked, j, held_field[j], got.field[j]);
                value_errors++;
            end
        end
        packets_checked++;
    endtask

    always @(negedge ap_clk) begin
        if (!areset_generator && out.valid) begin
            if (!model_running) begin
                $display("ERROR: %s output packet appeared while the merge was stopped",
                         test_name);
                other_errors++;
            end else begin
                check_packet(out.packet);
            end
        end
    end

    // Watchdog
    initial begin
        repeat (limit_cycles) @(posedge ap_clk);
        $display("ERROR: timeout in %s, run did not finish within %0d cycles",
                 test_name, limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        seed             = 41;
        value_errors     = 0;
        other_errors     = 0;
        packets_checked  = 0;
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg_mask         = '0;
        stop             = 1'b0;
        out_ready        = 1'b1;
        clear_lanes();
        model_mask       = '1;
        model_running    = 1'b0;
        held_meta        = '0;
        for (int j = 0; j < merge_types_pkg::num_lanes; j++) begin
            held_field[j] = '0;
        end
        test_name = "reset";
        repeat (5) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;
        @(negedge ap_clk);
        if (running !== 1'b0 || out.valid !== 1'b0 || lane_almost_full !== '0) begin
            $display("ERROR: running, out.valid or lane_almost_full not low after reset");
            other_errors++;
        end

        test_name = "full_merge";
        configure('1);
        push_beats(full_beats, '1, 0);
        wait_drain();
        stop_run();

        test_name = "masked_merge";
        for (int r = 0; r < masked_runs; r++) begin
            configure(random_mask());
            push_beats(masked_beats, '1, 0);
            wait_drain();
            stop_run();
        end

        // Zero mask is ignored, and so is a second mask during the run
        test_name = "control";
        configure('0);
        configure(4'b0011);
        configure(4'b1100);
        push_beats(ctrl_beats, '1, 0);
        wait_drain();
        stop_run();

        test_name = "back_pressure";
        @(posedge ap_clk);
        #2;
        out_ready = 1'b0;
        configure('1);
        fork
            push_beats(bp_beats, '1, bp_gap);
            begin
                wait (lane_almost_full != '0);
                @(posedge ap_clk);
                #2;
                out_ready = 1'b1;
            end
        join
        wait_drain();
        stop_run();

        test_name = "idle_hold";
        push_beats(idle_beats, '1, 0);
        repeat (20) @(posedge ap_clk);
        #2;
        configure(random_mask());
        wait_drain();
        stop_run();

        $display("Checked %0d packets: %0d value errors, %0d other errors",
                 packets_checked, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== merge_data_generator.f ====
merge_types_pkg.sv
merge_ctrl_pkg.sv
sync_fifo.sv
merge_control.sv
merge_gather.sv
merge_data_generator.sv
merge_data_generator_sva.sv
merge_data_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

verilator --binary --timing --assert -Wno-fatal \
    --top-module merge_data_generator_tb \
    -f merge_data_generator.f -o sim_merge_tb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_merge_tb > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
